//--- design/adc_cfg_if.sv
// Decoded configuration bus
interface adc_cfg_if #(
    parameter int N_CHANNELS = 4
);
    import adc_types_pkg::*;

    // Calibration, one entry per channel
    sample_t offset     [N_CHANNELS];
    shift_t  gain_shift [N_CHANNELS];

    ratio_t  decimation_ratio;

    // Fast stream comparator
    sample_t threshold_high;
    sample_t threshold_low;
    logic    latch_mode;
    logic    clear_latch;

    modport ctrl (
        output offset, gain_shift, decimation_ratio,
        output threshold_high, threshold_low, latch_mode, clear_latch
    );

    modport lane (input offset, gain_shift, decimation_ratio);

    modport monitor (input threshold_high, threshold_low, latch_mode, clear_latch);

endinterface

//--- design/adc_control_unit.sv
// Configuration register file
module adc_control_unit #(
    parameter int N_CHANNELS = 4
) (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      cfg_write,
    input  adc_regmap_pkg::cfg_addr_t cfg_addr,
    input  adc_regmap_pkg::cfg_data_t cfg_data,
    adc_cfg_if.ctrl                   cfg
);
    import adc_types_pkg::*;
    import adc_regmap_pkg::*;

    // Per-channel calibration registers
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int c = 0; c < N_CHANNELS; c++) begin
                cfg.offset[c]     <= '0;
                cfg.gain_shift[c] <= '0;
            end
        end else if (cfg_write) begin
            // Only addresses of existing channels match
            for (int c = 0; c < N_CHANNELS; c++) begin
                if (cfg_addr == ADDR_OFFSET_BASE + cfg_addr_t'(c)) begin
                    cfg.offset[c] <= sample_t'(cfg_data);
                end
                if (cfg_addr == ADDR_SHIFT_BASE + cfg_addr_t'(c)) begin
                    cfg.gain_shift[c] <= cfg_data[$bits(shift_t)-1:0];
                end
            end
        end
    end

    // Global settings
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            cfg.decimation_ratio <= '0;
            // Widest window so nothing trips until programmed
            cfg.threshold_high   <= SAMPLE_MAX;
            cfg.threshold_low    <= SAMPLE_MIN;
            cfg.latch_mode       <= 1'b0;
        end else if (cfg_write) begin
            case (cfg_addr)
                ADDR_RATIO: begin
                    cfg.decimation_ratio <= cfg_data[$bits(ratio_t)-1:0];
                end
                ADDR_THRESH_HIGH: begin
                    cfg.threshold_high <= sample_t'(cfg_data);
                end
                ADDR_THRESH_LOW: begin
                    cfg.threshold_low <= sample_t'(cfg_data);
                end
                ADDR_CONTROL: begin
                    cfg.latch_mode <= cfg_data[CTRL_LATCH_BIT];
                end
                default: begin
                end
            endcase
        end
    end

    // Clear pulse lasts one cycle after the control write
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            cfg.clear_latch <= 1'b0;
        end else begin
            cfg.clear_latch <= cfg_write && (cfg_addr == ADDR_CONTROL)
                               && cfg_data[CTRL_CLEAR_BIT];
        end
    end

endmodule

//--- design/adc_processing.sv
// ADC sample processing top
module adc_processing #(
    parameter int N_CHANNELS = 4
) (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  adc_types_pkg::sample_t    in_data,
    input  adc_types_pkg::channel_t   in_channel,
    input  logic                      cfg_write,
    input  adc_regmap_pkg::cfg_addr_t cfg_addr,
    input  adc_regmap_pkg::cfg_data_t cfg_data,
    output logic                      fast_valid,
    output adc_types_pkg::sample_t    fast_data,
    output adc_types_pkg::channel_t   fast_channel,
    output logic                      filtered_valid,
    output adc_types_pkg::sample_t    filtered_data,
    output adc_types_pkg::channel_t   filtered_channel,
    output logic                      trip_high,
    output logic                      trip_low
);
    import adc_types_pkg::*;

    logic [N_CHANNELS-1:0] lane_valid;
    sample_t               lane_data;
    logic [N_CHANNELS-1:0] cal_valid;
    sample_t               cal_data [N_CHANNELS];
    logic [N_CHANNELS-1:0] cal_keep;

    adc_cfg_if #(.N_CHANNELS(N_CHANNELS)) cfg_bus ();

    adc_control_unit #(.N_CHANNELS(N_CHANNELS)) u_control_unit (
        .clock     (clock),
        .rst_n     (rst_n),
        .cfg_write (cfg_write),
        .cfg_addr  (cfg_addr),
        .cfg_data  (cfg_data),
        .cfg       (cfg_bus)
    );

    sample_dispatcher #(.N_CHANNELS(N_CHANNELS)) u_dispatcher (
        .clock      (clock),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_channel (in_channel),
        .lane_valid (lane_valid),
        .lane_data  (lane_data)
    );

    // One calibration lane per channel
    for (genvar c = 0; c < N_CHANNELS; c++) begin : g_lane
        channel_calibrator #(.CHANNEL(c)) u_calibrator (
            .clock        (clock),
            .rst_n        (rst_n),
            .cfg          (cfg_bus),
            .sample_valid (lane_valid[c]),
            .sample_data  (lane_data),
            .cal_valid    (cal_valid[c]),
            .cal_data     (cal_data[c]),
            .cal_keep     (cal_keep[c])
        );
    end

    result_merger #(.N_CHANNELS(N_CHANNELS)) u_merger (
        .clock            (clock),
        .rst_n            (rst_n),
        .cfg              (cfg_bus),
        .cal_valid        (cal_valid),
        .cal_data         (cal_data),
        .cal_keep         (cal_keep),
        .fast_valid       (fast_valid),
        .fast_data        (fast_data),
        .fast_channel     (fast_channel),
        .filtered_valid   (filtered_valid),
        .filtered_data    (filtered_data),
        .filtered_channel (filtered_channel),
        .trip_high        (trip_high),
        .trip_low         (trip_low)
    );

endmodule

//--- design/adc_regmap_pkg.sv
// Configuration register map
package adc_regmap_pkg;

    typedef logic [3:0] cfg_addr_t;
    typedef logic [15:0] cfg_data_t;

    // Per-channel offsets sit at base + channel
    localparam cfg_addr_t ADDR_OFFSET_BASE = 4'd0;

    // Global settings
    localparam cfg_addr_t ADDR_RATIO       = 4'd4;
    localparam cfg_addr_t ADDR_THRESH_HIGH = 4'd5;
    localparam cfg_addr_t ADDR_THRESH_LOW  = 4'd6;
    localparam cfg_addr_t ADDR_CONTROL     = 4'd7;

    // Per-channel gain shifts sit at base + channel, low 2 bits
    localparam cfg_addr_t ADDR_SHIFT_BASE = 4'd8;

    // Control register bits
    localparam int CTRL_LATCH_BIT = 0;
    // Write-only, reads back nothing
    localparam int CTRL_CLEAR_BIT = 1;

endpackage

//--- design/adc_types_pkg.sv
// ADC data path types
package adc_types_pkg;

    // Raw and calibrated sample width
    localparam int SAMPLE_WIDTH = 16;

    // Headroom for offset carry plus a gain shift of up to 3
    localparam int WIDE_WIDTH = SAMPLE_WIDTH + 4;

    // Upper bound on the number of lanes a channel number can address
    localparam int MAX_CHANNELS = 8;

    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
    typedef logic signed [WIDE_WIDTH-1:0] wide_sample_t;
    typedef logic [2:0] channel_t;

    // Left shift of 0 to 3 bit positions
    typedef logic [1:0] shift_t;

    // Decimation ratio minus one, r keeps one sample in r+1
    typedef logic [3:0] ratio_t;

    // Saturation limits of a sample
    localparam sample_t SAMPLE_MAX = {1'b0, {(SAMPLE_WIDTH-1){1'b1}}};
    localparam sample_t SAMPLE_MIN = {1'b1, {(SAMPLE_WIDTH-1){1'b0}}};

endpackage

//--- design/channel_calibrator.sv
// Per-channel calibration and decimation
module channel_calibrator #(
    parameter int CHANNEL = 0
) (
    input  logic                   clock,
    input  logic                   rst_n,
    adc_cfg_if.lane                cfg,
    input  logic                   sample_valid,
    input  adc_types_pkg::sample_t sample_data,
    output logic                   cal_valid,
    output adc_types_pkg::sample_t cal_data,
    output logic                   cal_keep
);
    import adc_types_pkg::*;

    wide_sample_t with_offset;
    wide_sample_t scaled;
    sample_t      saturated;
    ratio_t       dec_count;
    logic         keep_now;

    // Offset and gain in wide precision, then clamp
    always_comb begin
        with_offset = wide_sample_t'(sample_data) + wide_sample_t'(cfg.offset[CHANNEL]);
        scaled      = with_offset <<< cfg.gain_shift[CHANNEL];
        if (scaled > wide_sample_t'(SAMPLE_MAX)) begin
            saturated = SAMPLE_MAX;
        end else if (scaled < wide_sample_t'(SAMPLE_MIN)) begin
            saturated = SAMPLE_MIN;
        end else begin
            saturated = scaled[$bits(sample_t)-1:0];
        end
    end

    // Also catches a count left above a freshly lowered ratio
    assign keep_now = (dec_count >= cfg.decimation_ratio);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            dec_count <= '0;
            cal_valid <= 1'b0;
            cal_keep  <= 1'b0;
        end else begin
            cal_valid <= sample_valid;
            cal_keep  <= sample_valid && keep_now;
            if (sample_valid) begin
                if (keep_now) begin
                    dec_count <= '0;
                end else begin
                    dec_count <= dec_count + ratio_t'(1);
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (sample_valid) begin
            cal_data <= saturated;
        end
    end

endmodule

//--- design/result_merger.sv
// Lane merger and fast comparator
module result_merger #(
    parameter int N_CHANNELS = 4
) (
    input  logic                    clock,
    input  logic                    rst_n,
    adc_cfg_if.monitor              cfg,
    input  logic [N_CHANNELS-1:0]   cal_valid,
    input  adc_types_pkg::sample_t  cal_data [N_CHANNELS],
    input  logic [N_CHANNELS-1:0]   cal_keep,
    output logic                    fast_valid,
    output adc_types_pkg::sample_t  fast_data,
    output adc_types_pkg::channel_t fast_channel,
    output logic                    filtered_valid,
    output adc_types_pkg::sample_t  filtered_data,
    output adc_types_pkg::channel_t filtered_channel,
    output logic                    trip_high,
    output logic                    trip_low
);
    import adc_types_pkg::*;

    logic     sel_valid;
    logic     sel_keep;
    sample_t  sel_data;
    channel_t sel_channel;
    logic     above_high;
    logic     below_low;

    // At most one lane is valid per cycle
    always_comb begin
        sel_valid   = 1'b0;
        sel_keep    = 1'b0;
        sel_data    = '0;
        sel_channel = '0;
        for (int i = 0; i < N_CHANNELS; i++) begin
            if (cal_valid[i]) begin
                sel_valid   = 1'b1;
                sel_keep    = cal_keep[i];
                sel_data    = cal_data[i];
                sel_channel = channel_t'(i);
            end
        end
    end

    assign above_high = sel_valid && (sel_data > cfg.threshold_high);
    assign below_low  = sel_valid && (sel_data < cfg.threshold_low);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            fast_valid     <= 1'b0;
            filtered_valid <= 1'b0;
            trip_high      <= 1'b0;
            trip_low       <= 1'b0;
        end else begin
            fast_valid     <= sel_valid;
            filtered_valid <= sel_valid && sel_keep;
            if (cfg.latch_mode) begin
                // Clear drops the held state, the current sample still counts
                trip_high <= (trip_high && !cfg.clear_latch) || above_high;
                trip_low  <= (trip_low && !cfg.clear_latch) || below_low;
            end else if (sel_valid) begin
                trip_high <= above_high;
                trip_low  <= below_low;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (sel_valid) begin
            fast_data    <= sel_data;
            fast_channel <= sel_channel;
        end
        if (sel_valid && sel_keep) begin
            filtered_data    <= sel_data;
            filtered_channel <= sel_channel;
        end
    end

endmodule

//--- design/sample_dispatcher.sv
// Sample to lane dispatcher
module sample_dispatcher #(
    parameter int N_CHANNELS = 4
) (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  adc_types_pkg::sample_t    in_data,
    input  adc_types_pkg::channel_t   in_channel,
    output logic [N_CHANNELS-1:0]     lane_valid,
    output adc_types_pkg::sample_t    lane_data
);
    import adc_types_pkg::*;

    // Decode over every addressable channel
    logic [MAX_CHANNELS-1:0] channel_onehot;

    always_comb begin
        channel_onehot = MAX_CHANNELS'(1) << in_channel;
    end

    // Channels without a lane fall off the top of the one-hot
    // and produce no strobe at all
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            lane_valid <= '0;
        end else if (in_valid) begin
            lane_valid <= channel_onehot[N_CHANNELS-1:0];
        end else begin
            lane_valid <= '0;
        end
    end

    // Sample shared by all lanes
    always_ff @(posedge clock) begin
        if (in_valid) begin
            lane_data <= in_data;
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the ADC processing testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module adc_processing_tb \
    --Mdir obj_dir -o adc_processing_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/adc_processing_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" sim.log; then
    exit 1
fi
exit 0

//--- sim.f
design/adc_types_pkg.sv
design/adc_regmap_pkg.sv
design/adc_cfg_if.sv
design/adc_control_unit.sv
design/sample_dispatcher.sv
design/channel_calibrator.sv
design/result_merger.sv
design/adc_processing.sv
testbench/adc_processing_tb.sv

//--- testbench/adc_processing_tb.sv
// ADC processing testbench
module adc_processing_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import adc_types_pkg::*;
    import adc_regmap_pkg::*;

    localparam int N_LANES = 4;
    localparam int DRAIN_TIMEOUT = 64;

    logic      clock;
    logic      rst_n;
    logic      in_valid;
    sample_t   in_data;
    channel_t  in_channel;
    logic      cfg_write;
    cfg_addr_t cfg_addr;
    cfg_data_t cfg_data;
    logic      fast_valid;
    sample_t   fast_data;
    channel_t  fast_channel;
    logic      filtered_valid;
    sample_t   filtered_data;
    channel_t  filtered_channel;
    logic      trip_high;
    logic      trip_low;

    // Reference model state
    int model_offset [N_LANES];
    int model_shift  [N_LANES];
    int model_count  [N_LANES];
    int model_ratio;
    int model_high;
    int model_low;
    bit model_latch;
    bit model_trip_high;
    bit model_trip_low;

    // Expected fast outputs in order
    int exp_data [$];
    int exp_channel [$];
    bit exp_keep [$];
    bit exp_trip_high [$];
    bit exp_trip_low [$];

    integer seed;
    string  test_name;
    int     error_count;
    int     check_count;
    int     test_count;
    int     errors_at_start;

    adc_processing #(.N_CHANNELS(N_LANES)) u_adc_processing (
        .clock            (clock),
        .rst_n            (rst_n),
        .in_valid         (in_valid),
        .in_data          (in_data),
        .in_channel       (in_channel),
        .cfg_write        (cfg_write),
        .cfg_addr         (cfg_addr),
        .cfg_data         (cfg_data),
        .fast_valid       (fast_valid),
        .fast_data        (fast_data),
        .fast_channel     (fast_channel),
        .filtered_valid   (filtered_valid),
        .filtered_data    (filtered_data),
        .filtered_channel (filtered_channel),
        .trip_high        (trip_high),
        .trip_low         (trip_low)
    );

    always #50 clock = ~clock;

    task automatic check_value(input string field, input int expected, input int actual);
        check_count++;
        if (expected != actual) begin
            error_count++;
            $display("MISMATCH %s %s: expected %0d, actual %0d",
                     test_name, field, expected, actual);
        end
    endtask

    // Offset, gain shift and clamp to the signed 16-bit range
    function automatic int calibrate(input int sample, input int offset, input int shift);
        int value;
        value = (sample + offset) * (1 << shift);
        if (value > 32767) begin
            value = 32767;
        end else if (value < -32768) begin
            value = -32768;
        end
        return value;
    endfunction

    // Outputs are compared in the middle of the cycle
    always @(negedge clock) begin : monitor
        int e_data;
        int e_channel;
        bit e_keep;
        bit e_high;
        bit e_low;
        if (rst_n && fast_valid) begin
            if (exp_data.size() == 0) begin
                error_count++;
                $display("ERROR: fast output with no expected sample in test %s", test_name);
            end else begin
                e_data    = exp_data.pop_front();
                e_channel = exp_channel.pop_front();
                e_keep    = exp_keep.pop_front();
                e_high    = exp_trip_high.pop_front();
                e_low     = exp_trip_low.pop_front();
                check_value("fast_data", e_data, int'(fast_data));
                check_value("fast_channel", e_channel, int'(fast_channel));
                check_value("filtered_valid", int'(e_keep), int'(filtered_valid));
                if (e_keep) begin
                    check_value("filtered_data", e_data, int'(filtered_data));
                    check_value("filtered_channel", e_channel, int'(filtered_channel));
                end
                check_value("trip_high", int'(e_high), int'(trip_high));
                check_value("trip_low", int'(e_low), int'(trip_low));
            end
        end else if (rst_n && filtered_valid) begin
            error_count++;
            $display("ERROR: filtered output without a fast output in test %s", test_name);
        end
    end

    task automatic apply_reset();
        @(posedge clock);
        #5;
        rst_n = 1'b0;
        in_valid = 1'b0;
        cfg_write = 1'b0;
        repeat (16) @(posedge clock);
        #5;
        rst_n = 1'b1;
        for (int c = 0; c < N_LANES; c++) begin
            model_offset[c] = 0;
            model_shift[c] = 0;
            model_count[c] = 0;
        end
        model_ratio = 0;
        model_high = 32767;
        model_low = -32768;
        model_latch = 1'b0;
        model_trip_high = 1'b0;
        model_trip_low = 1'b0;
    endtask

    task automatic write_reg(input int addr, input int data);
        @(posedge clock);
        #5;
        cfg_write = 1'b1;
        cfg_addr = cfg_addr_t'(addr);
        cfg_data = cfg_data_t'(data);
        @(posedge clock);
        #5;
        cfg_write = 1'b0;
    endtask

    // Drives one sample and predicts its fast output
    task automatic drive_sample(input int data, input int channel);
        int value;
        bit keep;
        bit above;
        bit below;
        @(posedge clock);
        #5;
        in_valid = 1'b1;
        in_data = sample_t'(data);
        in_channel = channel_t'(channel);
        if (channel < N_LANES) begin
            value = calibrate(data, model_offset[channel], model_shift[channel]);
            keep = (model_count[channel] == model_ratio);
            model_count[channel] = keep ? 0 : model_count[channel] + 1;
            above = (value > model_high);
            below = (value < model_low);
            if (model_latch) begin
                model_trip_high = model_trip_high | above;
                model_trip_low = model_trip_low | below;
            end else begin
                model_trip_high = above;
                model_trip_low = below;
            end
            exp_data.push_back(value);
            exp_channel.push_back(channel);
            exp_keep.push_back(keep);
            exp_trip_high.push_back(model_trip_high);
            exp_trip_low.push_back(model_trip_low);
        end
    endtask

    task automatic stop_input();
        @(posedge clock);
        #5;
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_data.size() != 0 && cycles < DRAIN_TIMEOUT) begin
            @(posedge clock);
            cycles++;
        end
        if (exp_data.size() != 0) begin
            error_count++;
            $display("ERROR: no output within timeout in test %s", test_name);
            exp_data.delete();
            exp_channel.delete();
            exp_keep.delete();
            exp_trip_high.delete();
            exp_trip_low.delete();
        end
        // Long enough for a stray output to leave the pipeline
        repeat (4) @(posedge clock);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        errors_at_start = error_count;
        apply_reset();
    endtask

    task automatic finish_test();
        test_count++;
        $display("test %s: %0d errors", test_name, error_count - errors_at_start);
    endtask

    // Random stream on lane channels, or on every channel number
    task automatic send_random(input int count, input int channel_mask, input bit extremes);
        int rnd;
        int data;
        for (int i = 0; i < count; i++) begin
            rnd = $random(seed);
            data = int'(sample_t'(rnd));
            if (extremes && (rnd & 32'h30000) == 32'h10000) begin
                data = 32767 - (rnd & 255);
            end else if (extremes && (rnd & 32'h30000) == 32'h20000) begin
                data = -32768 + (rnd & 255);
            end
            drive_sample(data, $random(seed) & channel_mask);
        end
        stop_input();
        wait_drain();
    endtask

    initial begin
        clock = 1'b0;
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_data = '0;
        in_channel = '0;
        cfg_write = 1'b0;
        cfg_addr = '0;
        cfg_data = '0;
        seed = 5;
        error_count = 0;
        check_count = 0;
        test_count = 0;

        start_test("identity");
        send_random(40, 3, 1'b0);
        finish_test();

        start_test("calibration");
        for (int c = 0; c < N_LANES; c++) begin
            model_offset[c] = int'(sample_t'($random(seed)));
            model_shift[c] = $random(seed) & 3;
            write_reg(ADDR_OFFSET_BASE + c, model_offset[c]);
            write_reg(ADDR_SHIFT_BASE + c, model_shift[c]);
        end
        send_random(80, 3, 1'b1);
        finish_test();

        start_test("decimation");
        // Ratio of 1 to 15 so that some samples are dropped
        model_ratio = 1 + (($random(seed) & 15) % 15);
        write_reg(ADDR_RATIO, model_ratio);
        send_random(120, 3, 1'b0);
        finish_test();

        start_test("threshold");
        model_high = int'(sample_t'($random(seed)));
        model_low = int'(sample_t'($random(seed)));
        write_reg(ADDR_THRESH_HIGH, model_high);
        write_reg(ADDR_THRESH_LOW, model_low);
        send_random(60, 3, 1'b0);
        finish_test();

        start_test("latching");
        model_high = 1000;
        model_low = -1000;
        model_latch = 1'b1;
        write_reg(ADDR_THRESH_HIGH, model_high);
        write_reg(ADDR_THRESH_LOW, model_low);
        write_reg(ADDR_CONTROL, 1 << CTRL_LATCH_BIT);
        drive_sample(5000, 0);
        drive_sample(-5000, 1);
        for (int i = 0; i < 8; i++) begin
            drive_sample($random(seed) % 1000, $random(seed) & 3);
        end
        stop_input();
        wait_drain();
        write_reg(ADDR_CONTROL, (1 << CTRL_LATCH_BIT) | (1 << CTRL_CLEAR_BIT));
        model_trip_high = 1'b0;
        model_trip_low = 1'b0;
        // Clear pulse lands one edge after the write
        @(posedge clock);
        @(negedge clock);
        check_value("trip_high after clear", 0, int'(trip_high));
        check_value("trip_low after clear", 0, int'(trip_low));
        for (int i = 0; i < 4; i++) begin
            drive_sample($random(seed) % 1000, $random(seed) & 3);
        end
        drive_sample(2000, 2);
        drive_sample(-2000, 1);
        drive_sample(0, 3);
        stop_input();
        wait_drain();
        finish_test();

        start_test("dropped");
        send_random(60, 7, 1'b0);
        finish_test();

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
